//--- hdl/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm_t;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // SPECIAL function field, bits 5:0
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

endpackage

`default_nettype wire

//--- hdl/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

    // What the main decoder wants from the ALU
    typedef enum logic [1:0] {
        ALU_CLS_ADD       = 2'd0,
        ALU_CLS_SUB       = 2'd1,
        ALU_CLS_FUNCT     = 2'd2,
        ALU_CLS_IMM_LOGIC = 2'd3
    } alu_class_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_LUI  = 4'd7
    } alu_func_e;

    // Boot address in kseg1 ROM
    localparam mips_isa_pkg::word_t reset_vector = 32'hBFC0_0000;

endpackage

`default_nettype wire

//--- hdl/control.sv
`default_nettype none

module control (
    input  mips_isa_pkg::opcode_e     opcode,
    input  mips_isa_pkg::funct_e      funct,
    output logic                      reg_dst,
    output logic                      branch,
    output logic                      branch_ne,
    output logic                      jump,
    output logic                      jump_reg,
    output logic                      link,
    output logic                      mem_read,
    output logic                      mem_to_reg,
    output logic                      mem_write,
    output logic                      alu_src,
    output logic                      zero_ext,
    output logic                      reg_write,
    output mips_ctrl_pkg::alu_class_e alu_class
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    always_comb begin
        reg_dst    = 1'b0;
        branch     = 1'b0;
        branch_ne  = 1'b0;
        jump       = 1'b0;
        jump_reg   = 1'b0;
        link       = 1'b0;
        mem_read   = 1'b0;
        mem_to_reg = 1'b0;
        mem_write  = 1'b0;
        alu_src    = 1'b0;
        zero_ext   = 1'b0;
        reg_write  = 1'b0;
        alu_class  = ALU_CLS_ADD;
        case (opcode)
            OP_SPECIAL: begin
                alu_class = ALU_CLS_FUNCT;
                case (funct)
                    FN_JR: jump_reg = 1'b1;
                    FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU: begin
                        reg_dst   = 1'b1;
                        reg_write = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_J: jump = 1'b1;
            OP_JAL: begin
                jump      = 1'b1;
                link      = 1'b1;
                reg_write = 1'b1;
            end
            // Branches compare rs and rt by subtraction
            OP_BEQ: begin
                branch    = 1'b1;
                alu_class = ALU_CLS_SUB;
            end
            OP_BNE: begin
                branch_ne = 1'b1;
                alu_class = ALU_CLS_SUB;
            end
            OP_ADDIU: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_SLTI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_class = ALU_CLS_IMM_LOGIC;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                alu_src   = 1'b1;
                zero_ext  = 1'b1;
                reg_write = 1'b1;
                alu_class = ALU_CLS_IMM_LOGIC;
            end
            OP_LW: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu_control.sv
`default_nettype none

module alu_control (
    input  mips_ctrl_pkg::alu_class_e alu_class,
    input  mips_isa_pkg::funct_e      funct,
    input  mips_isa_pkg::opcode_e     opcode,
    output mips_ctrl_pkg::alu_func_e  alu_func
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    always_comb begin
        alu_func = ALU_ADD;
        case (alu_class)
            ALU_CLS_ADD: alu_func = ALU_ADD;
            ALU_CLS_SUB: alu_func = ALU_SUB;
            ALU_CLS_FUNCT: begin
                case (funct)
                    FN_SUBU: alu_func = ALU_SUB;
                    FN_AND:  alu_func = ALU_AND;
                    FN_OR:   alu_func = ALU_OR;
                    FN_XOR:  alu_func = ALU_XOR;
                    FN_SLT:  alu_func = ALU_SLT;
                    FN_SLTU: alu_func = ALU_SLTU;
                    // ADDU, and JR where the result is unused
                    default: alu_func = ALU_ADD;
                endcase
            end
            ALU_CLS_IMM_LOGIC: begin
                case (opcode)
                    OP_SLTI: alu_func = ALU_SLT;
                    OP_ANDI: alu_func = ALU_AND;
                    OP_ORI:  alu_func = ALU_OR;
                    OP_XORI: alu_func = ALU_XOR;
                    OP_LUI:  alu_func = ALU_LUI;
                    default: alu_func = ALU_ADD;
                endcase
            end
            default: alu_func = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none

module alu (
    input  mips_ctrl_pkg::alu_func_e func,
    input  mips_isa_pkg::word_t      op1,
    input  mips_isa_pkg::word_t      op2,
    output mips_isa_pkg::word_t      result,
    output logic                     zero
);
    import mips_ctrl_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(op1) < $signed(op2);
    assign lt_unsigned = op1 < op2;

    always_comb begin
        case (func)
            ALU_ADD:  result = op1 + op2;
            ALU_SUB:  result = op1 - op2;
            ALU_AND:  result = op1 & op2;
            ALU_OR:   result = op1 | op2;
            ALU_XOR:  result = op1 ^ op2;
            ALU_SLT:  result = {31'b0, lt_signed};
            ALU_SLTU: result = {31'b0, lt_unsigned};
            // Immediate into the upper half
            ALU_LUI:  result = op2 << 16;
            default:  result = '0;
        endcase
    end

    // Used by BEQ/BNE after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`default_nettype none

module regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clk_enable,
    input  logic                   write_enable,
    input  mips_isa_pkg::reg_idx_t read_reg1,
    input  mips_isa_pkg::reg_idx_t read_reg2,
    input  mips_isa_pkg::reg_idx_t write_reg,
    input  mips_isa_pkg::word_t    write_data,
    output mips_isa_pkg::word_t    read_data1,
    output mips_isa_pkg::word_t    read_data2,
    output mips_isa_pkg::word_t    register_v0
);
    import mips_isa_pkg::*;

    word_t regs [32];

    // $0 is never written, so it keeps its reset value
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable && write_enable && (write_reg != '0)) begin
            regs[write_reg] <= write_data;
        end
    end

    assign read_data1  = regs[read_reg1];
    assign read_data2  = regs[read_reg2];
    assign register_v0 = regs[2];

    zero_reg_a: assert property (
        @(posedge clk) disable iff (rst)
        (read_reg1 == '0) |-> (read_data1 == '0)
    ) else $error("regfile: $0 read as nonzero on port 1");

    zero_reg_b: assert property (
        @(posedge clk) disable iff (rst)
        (read_reg2 == '0) |-> (read_data2 == '0)
    ) else $error("regfile: $0 read as nonzero on port 2");

endmodule

`default_nettype wire

//--- hdl/pc.sv
`default_nettype none

module pc #(
    parameter mips_isa_pkg::word_t reset_addr = mips_ctrl_pkg::reset_vector
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_enable,
    input  logic                take_branch,
    input  logic                jump,
    input  logic                jump_reg,
    input  mips_isa_pkg::word_t branch_offset,
    input  mips_isa_pkg::word_t jump_target,
    input  mips_isa_pkg::word_t reg_target,
    output mips_isa_pkg::word_t curr_addr,
    output logic                active
);
    import mips_isa_pkg::*;

    word_t addr_p4;
    word_t next_addr;

    assign addr_p4 = curr_addr + 32'd4;

    // Branch, then J/JAL, then JR, else sequential
    always_comb begin
        if (take_branch) begin
            next_addr = addr_p4 + (branch_offset << 2);
        end else if (jump) begin
            next_addr = {addr_p4[31:28], jump_target[27:0]};
        end else if (jump_reg) begin
            next_addr = reg_target;
        end else begin
            next_addr = addr_p4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            curr_addr <= reset_addr;
            active    <= 1'b1;
        end else if (clk_enable && active) begin
            curr_addr <= next_addr;
            // Jump to address 0 ends the program
            if (next_addr == '0) begin
                active <= 1'b0;
            end
        end
    end

    pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        active |-> (curr_addr[1:0] == 2'b00)
    ) else $error("pc: misaligned fetch address %h", curr_addr);

endmodule

`default_nettype wire

//--- hdl/mips_cpu_harvard.sv
`default_nettype none

module mips_cpu_harvard #(
    parameter mips_isa_pkg::word_t reset_addr = mips_ctrl_pkg::reset_vector
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_enable,
    output logic                active,
    output mips_isa_pkg::word_t register_v0,

    output mips_isa_pkg::word_t instr_address,
    input  mips_isa_pkg::word_t instr_readdata,

    output mips_isa_pkg::word_t data_address,
    output logic                data_read,
    output logic                data_write,
    output mips_isa_pkg::word_t data_writedata,
    input  mips_isa_pkg::word_t data_readdata
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    opcode_e    opcode;
    funct_e     funct;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    imm_t       imm;
    word_t      imm_ext;
    word_t      jump_target;

    logic       reg_dst;
    logic       branch;
    logic       branch_ne;
    logic       jump;
    logic       jump_reg;
    logic       link;
    logic       mem_read;
    logic       mem_to_reg;
    logic       mem_write;
    logic       alu_src;
    logic       zero_ext;
    logic       reg_write;
    alu_class_e alu_class;
    alu_func_e  alu_func;

    word_t      rs_data;
    word_t      rt_data;
    word_t      alu_op2;
    word_t      alu_result;
    logic       alu_zero;
    logic       take_branch;

    reg_idx_t   wb_reg;
    word_t      wb_data;
    word_t      return_addr;

    // Instruction fields
    assign opcode      = opcode_e'(instr_readdata[31:26]);
    assign funct       = funct_e'(instr_readdata[5:0]);
    assign rs          = instr_readdata[25:21];
    assign rt          = instr_readdata[20:16];
    assign rd          = instr_readdata[15:11];
    assign imm         = instr_readdata[15:0];
    assign imm_ext     = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    assign jump_target = {4'b0000, instr_readdata[25:0], 2'b00};

    control u_control (
        .opcode     (opcode),
        .funct      (funct),
        .reg_dst    (reg_dst),
        .branch     (branch),
        .branch_ne  (branch_ne),
        .jump       (jump),
        .jump_reg   (jump_reg),
        .link       (link),
        .mem_read   (mem_read),
        .mem_to_reg (mem_to_reg),
        .mem_write  (mem_write),
        .alu_src    (alu_src),
        .zero_ext   (zero_ext),
        .reg_write  (reg_write),
        .alu_class  (alu_class)
    );

    alu_control u_alu_control (
        .alu_class (alu_class),
        .funct     (funct),
        .opcode    (opcode),
        .alu_func  (alu_func)
    );

    assign alu_op2 = alu_src ? imm_ext : rt_data;

    alu u_alu (
        .func   (alu_func),
        .op1    (rs_data),
        .op2    (alu_op2),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign take_branch = (branch && alu_zero) || (branch_ne && !alu_zero);

    // JAL links to $31, R-type writes rd, the rest write rt
    assign return_addr = instr_address + 32'd4;
    assign wb_reg      = link ? 5'd31 : (reg_dst ? rd : rt);
    assign wb_data     = link ? return_addr : (mem_to_reg ? data_readdata : alu_result);

    regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .clk_enable   (clk_enable),
        .write_enable (reg_write && active),
        .read_reg1    (rs),
        .read_reg2    (rt),
        .write_reg    (wb_reg),
        .write_data   (wb_data),
        .read_data1   (rs_data),
        .read_data2   (rt_data),
        .register_v0  (register_v0)
    );

    pc #(
        .reset_addr (reset_addr)
    ) u_pc (
        .clk           (clk),
        .rst           (rst),
        .clk_enable    (clk_enable),
        .take_branch   (take_branch),
        .jump          (jump),
        .jump_reg      (jump_reg),
        .branch_offset (imm_ext),
        .jump_target   (jump_target),
        .reg_target    (rs_data),
        .curr_addr     (instr_address),
        .active        (active)
    );

    // No memory traffic once halted
    assign data_address   = alu_result;
    assign data_read      = mem_read && active;
    assign data_write     = mem_write && active;
    assign data_writedata = rt_data;

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int period_ns = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- dv/mips_cpu_harvard_tb.sv
`default_nettype none

module mips_cpu_harvard_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    localparam int rom_words   = 256;
    localparam int ram_words   = 1024;
    localparam int max_cycles  = 2000;
    localparam int drive_delay = 2;
    localparam pattern_file    = "dv/mips_patterns.txt";

    logic  clk;
    logic  rst;
    logic  clk_enable;
    logic  active;
    word_t register_v0;
    word_t instr_address;
    word_t instr_readdata;
    word_t data_address;
    logic  data_read;
    logic  data_write;
    word_t data_writedata;
    word_t data_readdata;

    word_t rom [rom_words];
    word_t ram [ram_words];
    word_t rom_offset;
    word_t idle_instr;

    // Current case from the pattern file
    word_t           instr_q[$];
    word_t           data_addr_q[$];
    word_t           data_word_q[$];
    logic [8*32-1:0] case_name;
    word_t           exp_v0;
    word_t           chk_addr;
    word_t           chk_word;
    logic            stall_run;

    int value_errors = 0;
    int timeouts     = 0;
    int other_errors = 0;

    tb_clock u_clock (
        .clk (clk)
    );

    mips_cpu_harvard #(
        .reset_addr (reset_vector)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    // ROM sits at the reset vector
    // Fetches outside it return idle_instr
    assign rom_offset     = instr_address - reset_vector;
    assign instr_readdata = (rom_offset < rom_words * 4) ? rom[rom_offset[9:2]] : idle_instr;
    // RAM answers only on a read strobe
    assign data_readdata  = (data_read && data_address < ram_words * 4) ?
                            ram[data_address[11:2]] : '0;

    always @(posedge clk) begin
        if (!rst && clk_enable && (data_read || data_write)) begin
            if (!active) begin
                $display("data strobe seen at %0t ns after the CPU halted", $time);
                other_errors++;
            end
            if (data_address >= ram_words * 4) begin
                $display("data access at %0t ns outside the RAM, address %h",
                         $time, data_address);
                other_errors++;
            end else if (data_write) begin
                ram[data_address[11:2]] <= data_writedata;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    // About one cycle in four stalled when stalls are on
    function automatic logic enable_for_cycle(input logic stalls);
        return !stalls || (($urandom % 4) != 0);
    endfunction

    // Words fed to a halted CPU that would change its state if it still ran
    function automatic word_t halt_probe(input int i);
        word_t store_addr;
        store_addr = (chk_addr != '1) ? chk_addr : '0;
        case (i % 3)
            0:       return 32'h2442_0001;
            1:       return 32'h8c00_0000;
            default: return {16'hac00, store_addr[15:0]};
        endcase
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: case %0s stalls %0d, %0s is %h, expected %h",
                     $time, case_name, stall_run, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: case %0s stalls %0d, %0s is %b, expected %b",
                     $time, case_name, stall_run, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic load_memories();
        word_t addr;
        for (int i = 0; i < rom_words; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < ram_words; i++) begin
            ram[i] = '0;
        end
        foreach (instr_q[i]) begin
            rom[i] = instr_q[i];
        end
        foreach (data_addr_q[i]) begin
            addr           = data_addr_q[i];
            ram[addr[11:2]] = data_word_q[i];
        end
    endtask

    task automatic read_case(input int fd, output bit found);
        logic [8*32-1:0]  tok;
        logic [8*256-1:0] rest;
        word_t            addr;
        word_t            word;
        int               n_instr;
        int               n_data;
        int               code;
        bit               done;
        found = 1'b0;
        done  = 1'b0;
        instr_q.delete();
        data_addr_q.delete();
        data_word_q.delete();
        while (!found && !done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "case") begin
                code = $fscanf(fd, "%s %d %d %h %h %h", case_name, n_instr, n_data,
                               exp_v0, chk_addr, chk_word);
                if (code != 6 || n_instr > rom_words || n_data > ram_words ||
                    (chk_addr != '1 && chk_addr >= ram_words * 4)) begin
                    $display("bad case header in the pattern file");
                    other_errors++;
                    done = 1'b1;
                end else begin
                    for (int i = 0; i < n_instr; i++) begin
                        code = $fscanf(fd, "%h", word);
                        instr_q.push_back(word);
                    end
                    for (int i = 0; i < n_data; i++) begin
                        code = $fscanf(fd, "%h %h", addr, word);
                        data_addr_q.push_back(addr);
                        data_word_q.push_back(word);
                    end
                    found = 1'b1;
                end
            end else begin
                $display("unexpected token %0s in the pattern file", tok);
                other_errors++;
                done = 1'b1;
            end
        end
    endtask

    task automatic run_case(input logic stalls);
        int cycles;
        stall_run = stalls;
        next_cycle();
        rst        = 1'b1;
        clk_enable = 1'b0;
        idle_instr = '0;
        load_memories();
        repeat (16) next_cycle();
        rst = 1'b0;
        check_word(instr_address, reset_vector, "fetch address after reset");
        check_flag(active, 1'b1, "active after reset");
        check_word(register_v0, '0, "v0 after reset");

        cycles     = 0;
        clk_enable = enable_for_cycle(stalls);
        while (active && cycles < max_cycles) begin
            next_cycle();
            cycles++;
            clk_enable = enable_for_cycle(stalls);
        end

        if (active) begin
            $display("case %0s with stalls %0d did not halt within %0d cycles",
                     case_name, stalls, max_cycles);
            timeouts++;
        end else begin
            check_word(register_v0, exp_v0, "final v0");
            if (chk_addr != '1) begin
                check_word(ram[chk_addr[11:2]], chk_word, "final data word");
            end
            // Halted CPU must leave state alone
            for (int i = 0; i < 20; i++) begin
                idle_instr = halt_probe(i);
                next_cycle();
                clk_enable = enable_for_cycle(stalls);
            end
            idle_instr = '0;
            check_flag(active, 1'b0, "active after halt");
            check_word(register_v0, exp_v0, "v0 after halt");
            if (chk_addr != '1) begin
                check_word(ram[chk_addr[11:2]], chk_word, "data word after halt");
            end
        end
        clk_enable = 1'b0;
    endtask

    initial begin
        int fd;
        int n_cases;
        bit found;
        rst        = 1'b1;
        clk_enable = 1'b0;
        idle_instr = '0;
        stall_run  = 1'b0;
        case_name  = '0;
        n_cases    = 0;
        void'($urandom(43452));
        load_memories();

        fd = $fopen(pattern_file, "r");
        if (fd == 0) begin
            $display("could not open the pattern file %0s", pattern_file);
            other_errors++;
        end else begin
            read_case(fd, found);
            while (found) begin
                n_cases++;
                run_case(1'b0);
                run_case(1'b1);
                read_case(fd, found);
            end
            $fclose(fd);
            if (n_cases == 0) begin
                $display("no test cases found in the pattern file");
                other_errors++;
            end
        end

        $display("%0d cases, %0d wrong values, %0d timeouts, %0d other errors",
                 n_cases, value_errors, timeouts, other_errors);
        if (value_errors == 0 && timeouts == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/control.sv
hdl/alu_control.sv
hdl/alu.sv
hdl/regfile.sv
hdl/pc.sv
hdl/mips_cpu_harvard.sv
dv/tb_clock.sv
dv/mips_cpu_harvard_tb.sv

//--- Bender.yml
package:
  name: mips_cpu_harvard

sources:
  - hdl/mips_isa_pkg.sv
  - hdl/mips_ctrl_pkg.sv
  - hdl/control.sv
  - hdl/alu_control.sv
  - hdl/alu.sv
  - hdl/regfile.sv
  - hdl/pc.sv
  - hdl/mips_cpu_harvard.sv
  - target: simulation
    files:
      - dv/tb_clock.sv
      - dv/mips_cpu_harvard_tb.sv

//--- dv/mips_patterns.txt
# case <name> <instr words> <data pairs> <expected v0> <check addr, ffffffff for none> <word>
# then the instruction words in hex, then <address> <word> pairs preloaded into data RAM
case arith 12 0 00000011 ffffffff 00000000
2408fffb 24090007 01095021 01285823
0109602a 0128682b 290efffc 014b1021
004c1021 004e1021 004d1021 00000008

# zero-extended logic immediates and LUI
case logic 9 0 00008f0e ffffffff 00000000
3c081234 3508f0f0 2409ffff 312a8001
390bffff 010b6024 014c6825 01ab1026
00000008

# load, increment, store with a negative offset, reload
case memory 6 1 cafef00e 000001fc cafef00e
8c080100 25090001 240a0200 ad49fffc
8d42fffc 00000008
00000100 cafef00d

# BNE loop of five, then BEQ and BNE taken and not taken
case branch 12 0 0000003f ffffffff 00000000
24080005 24020000 24420003 2508ffff
1500fffd 11000001 24420064 10400001
24420010 14420001 24420020 00000008

# JAL to a subroutine, JR $31 back, J over a skipped add, JR $0 halts
case jump 8 0 00000007 ffffffff 00000000
24020001 0ff00006 24420004 0bf00005
24420040 00000008 24420002 03e00008
